//--- src/lsu_pkg.sv
package lsu_pkg;

  // funct3 encodings shared by loads and stores
  typedef enum logic [2:0] {
    OP_B  = 3'b000,  // LB / SB
    OP_H  = 3'b001,  // LH / SH
    OP_W  = 3'b010,  // LW / SW
    OP_BU = 3'b100,  // LBU
    OP_HU = 3'b101   // LHU
  } lsu_op_e;

  typedef enum logic [2:0] {
    REG_NONE,
    REG_MEM,
    REG_LEDR,
    REG_LEDG,
    REG_HEX_LO,
    REG_HEX_HI,
    REG_SW
  } lsu_region_e;

  localparam logic [31:0] MEM_START   = 32'h0000_2000;
  localparam logic [31:0] MEM_END     = 32'h0000_3FFF;
  localparam logic [31:0] LEDR_START  = 32'h0000_7000;
  localparam logic [31:0] LEDR_END    = 32'h0000_700F;
  localparam logic [31:0] LEDG_START  = 32'h0000_7010;
  localparam logic [31:0] LEDG_END    = 32'h0000_701F;
  localparam logic [31:0] HEX_LO_ADDR = 32'h0000_7020;  // Digits 0 to 3
  localparam logic [31:0] HEX_HI_ADDR = 32'h0000_7024;  // Digits 4 to 7
  localparam logic [31:0] SW_START    = 32'h0000_7800;
  localparam logic [31:0] SW_END      = 32'h0000_780F;

  localparam int DATA_W     = 32;
  localparam int LANES      = 4;
  localparam int LEDR_W     = 17;
  localparam int LEDG_W     = 8;
  localparam int SW_W       = 10;
  localparam int HEX_DIGITS = 8;
  localparam int HEX_SEG_W  = 7;

endpackage

//--- src/lsu_bus_if.sv
`timescale 1ns/1ps

interface lsu_bus_if #(
  parameter int MEM_WORDS = 256
);
  import lsu_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  lsu_region_e         region;
  lsu_op_e             op;
  logic [1:0]          offset;    // Byte offset within the word
  logic [IDX_W-1:0]    word_idx;  // Memory word index, aliased
  logic [LANES-1:0]    byte_en;   // Already gated by the write enable
  logic [DATA_W-1:0]   wdata;
  logic                wren;

  modport decode_mp (output region, op, offset, word_idx, byte_en, wdata, wren);
  modport mem_mp    (input word_idx, byte_en, wdata, region);
  modport io_mp     (input region, byte_en, wdata, wren);
  modport load_mp   (input region, op, offset, wren);

endinterface

//--- src/lsu_access_decode.sv
`timescale 1ns/1ps

module lsu_access_decode #(
  parameter int MEM_WORDS = 256
) (
  input  logic [31:0]               i_lsu_addr,
  input  logic                      i_lsu_wren,
  input  lsu_pkg::lsu_op_e          i_funct3,
  input  logic [lsu_pkg::DATA_W-1:0] i_st_data,
  lsu_bus_if.decode_mp              bus
);
  import lsu_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  lsu_region_e      region;
  logic [1:0]       offset;
  logic [LANES-1:0] lanes;
  logic             lane_region;

  assign offset = i_lsu_addr[1:0];

  // Address map lookup
  always_comb begin
    region = REG_NONE;
    if (i_lsu_addr >= MEM_START && i_lsu_addr <= MEM_END) begin
      region = REG_MEM;
    end else if (i_lsu_addr >= LEDR_START && i_lsu_addr <= LEDR_END) begin
      region = REG_LEDR;
    end else if (i_lsu_addr >= LEDG_START && i_lsu_addr <= LEDG_END) begin
      region = REG_LEDG;
    end else if (i_lsu_addr[31:2] == HEX_LO_ADDR[31:2]) begin
      region = REG_HEX_LO;
    end else if (i_lsu_addr[31:2] == HEX_HI_ADDR[31:2]) begin
      region = REG_HEX_HI;
    end else if (i_lsu_addr >= SW_START && i_lsu_addr <= SW_END) begin
      region = REG_SW;
    end
  end

  assign lane_region = (region == REG_MEM) || (region == REG_HEX_LO) ||
                       (region == REG_HEX_HI);

  // Lanes touched by the store, empty for illegal combinations
  always_comb begin
    case (i_funct3)
      OP_B:    lanes = LANES'(1) << offset;
      OP_H:    lanes = (offset <= 2'd2) ? (LANES'(3) << offset) : '0;
      OP_W:    lanes = (offset == 2'd0) ? '1 : '0;
      default: lanes = '0;  // BU/HU and unused codes are no stores
    endcase
  end

  assign bus.region   = region;
  assign bus.op       = i_funct3;
  assign bus.offset   = offset;
  assign bus.word_idx = i_lsu_addr[IDX_W+1:2];
  assign bus.wren     = i_lsu_wren;
  assign bus.byte_en  = (i_lsu_wren && lane_region) ? lanes : '0;

  // LED windows take the raw store data, byte-lane windows get it lane aligned
  assign bus.wdata    = lane_region ? (i_st_data << {offset, 3'b000}) : i_st_data;

endmodule

//--- src/lsu_data_mem.sv
`timescale 1ns/1ps

module lsu_data_mem #(
  parameter int MEM_WORDS = 256
) (
  input  logic                       i_clk,
  lsu_bus_if.mem_mp                  bus,
  output logic [lsu_pkg::DATA_W-1:0] o_rdata
);
  import lsu_pkg::*;

  localparam int BYTE_W = DATA_W / LANES;

  logic [DATA_W-1:0] mem_q [MEM_WORDS];

  // Byte-enabled write, lanes already aligned by the decoder
  always_ff @(posedge i_clk) begin
    if (bus.region == REG_MEM) begin
      for (int i = 0; i < LANES; i++) begin
        if (bus.byte_en[i]) begin
          mem_q[bus.word_idx][i*BYTE_W +: BYTE_W] <= bus.wdata[i*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  assign o_rdata = mem_q[bus.word_idx];  // Asynchronous read

endmodule

//--- src/lsu_io_regs.sv
`timescale 1ns/1ps

module lsu_io_regs (
  input  logic                                            i_clk,
  input  logic                                            i_rst,
  lsu_bus_if.io_mp                                        bus,
  input  logic [lsu_pkg::SW_W-1:0]                        i_io_sw,
  output logic [lsu_pkg::LEDR_W-1:0]                      o_io_ledr,
  output logic [lsu_pkg::LEDG_W-1:0]                      o_io_ledg,
  output logic [lsu_pkg::HEX_DIGITS*lsu_pkg::HEX_SEG_W-1:0] o_io_hex,
  output logic [lsu_pkg::DATA_W-1:0]                      o_rdata
);
  import lsu_pkg::*;

  localparam int BYTE_W = DATA_W / LANES;

  logic [BYTE_W-1:0] digit_q [HEX_DIGITS];
  logic [SW_W-1:0]   sw_q;
  logic [DATA_W-1:0] hex_lo_word;
  logic [DATA_W-1:0] hex_hi_word;

  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      o_io_ledr <= '0;
      o_io_ledg <= '0;
      sw_q      <= '0;
      for (int i = 0; i < HEX_DIGITS; i++) begin
        digit_q[i] <= '0;
      end
    end else begin
      sw_q <= i_io_sw;  // Sampled every cycle
      if (bus.wren && bus.region == REG_LEDR) o_io_ledr <= bus.wdata[LEDR_W-1:0];
      if (bus.wren && bus.region == REG_LEDG) o_io_ledg <= bus.wdata[LEDG_W-1:0];
      for (int i = 0; i < LANES; i++) begin
        if (bus.region == REG_HEX_LO && bus.byte_en[i]) begin
          digit_q[i] <= bus.wdata[i*BYTE_W +: BYTE_W];
        end
        if (bus.region == REG_HEX_HI && bus.byte_en[i]) begin
          digit_q[LANES+i] <= bus.wdata[i*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      hex_lo_word[i*BYTE_W +: BYTE_W] = digit_q[i];
      hex_hi_word[i*BYTE_W +: BYTE_W] = digit_q[LANES+i];
    end
  end

  always_comb begin
    case (bus.region)
      REG_HEX_LO: o_rdata = hex_lo_word;
      REG_HEX_HI: o_rdata = hex_hi_word;
      REG_LEDR:   o_rdata = DATA_W'(o_io_ledr);
      REG_LEDG:   o_rdata = DATA_W'(o_io_ledg);
      REG_SW:     o_rdata = DATA_W'(sw_q);
      default:    o_rdata = '0;
    endcase
  end

  // Segment outputs drop the top bit of each digit byte
  for (genvar g = 0; g < HEX_DIGITS; g++) begin : g_hex
    assign o_io_hex[g*HEX_SEG_W +: HEX_SEG_W] = digit_q[g][HEX_SEG_W-1:0];
  end

endmodule

//--- src/lsu_load_format.sv
`timescale 1ns/1ps

module lsu_load_format (
  lsu_bus_if.load_mp                 bus,
  input  logic [lsu_pkg::DATA_W-1:0] i_mem_rdata,
  input  logic [lsu_pkg::DATA_W-1:0] i_io_rdata,
  output logic [lsu_pkg::DATA_W-1:0] o_ld_data
);
  import lsu_pkg::*;

  logic [DATA_W-1:0] src_word;
  logic [DATA_W-1:0] shifted;

  assign src_word = (bus.region == REG_MEM) ? i_mem_rdata : i_io_rdata;
  assign shifted  = src_word >> {bus.offset, 3'b000};  // Addressed byte to lane 0

  always_comb begin
    o_ld_data = '0;
    if (!bus.wren) begin
      case (bus.region)
        REG_MEM, REG_HEX_LO, REG_HEX_HI: begin
          case (bus.op)
            OP_B:  o_ld_data = {{(DATA_W-8){shifted[7]}}, shifted[7:0]};
            OP_BU: o_ld_data = {{(DATA_W-8){1'b0}}, shifted[7:0]};
            OP_H: begin
              if (bus.offset != 2'd3) o_ld_data = {{(DATA_W-16){shifted[15]}}, shifted[15:0]};
            end
            OP_HU: begin
              if (bus.offset != 2'd3) o_ld_data = {{(DATA_W-16){1'b0}}, shifted[15:0]};
            end
            OP_W: begin
              if (bus.offset == 2'd0) o_ld_data = shifted;
            end
            default: o_ld_data = '0;
          endcase
        end
        REG_LEDR, REG_LEDG, REG_SW: o_ld_data = src_word;  // Already zero extended
        default:                    o_ld_data = '0;
      endcase
    end
  end

endmodule

//--- src/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  parameter int MEM_WORDS = 256
) (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic [31:0]                       i_lsu_addr,
  input  logic                              i_lsu_wren,
  input  logic [2:0]                        i_funct3,
  input  logic [lsu_pkg::DATA_W-1:0]        i_st_data,
  input  logic [lsu_pkg::SW_W-1:0]          i_io_sw,
  output logic [lsu_pkg::DATA_W-1:0]        o_ld_data,
  output logic [lsu_pkg::LEDR_W-1:0]        o_io_ledr,
  output logic [lsu_pkg::LEDG_W-1:0]        o_io_ledg,
  output logic [lsu_pkg::HEX_SEG_W-1:0]     o_io_hex0,
  output logic [lsu_pkg::HEX_SEG_W-1:0]     o_io_hex1,
  output logic [lsu_pkg::HEX_SEG_W-1:0]     o_io_hex2,
  output logic [lsu_pkg::HEX_SEG_W-1:0]     o_io_hex3,
  output logic [lsu_pkg::HEX_SEG_W-1:0]     o_io_hex4,
  output logic [lsu_pkg::HEX_SEG_W-1:0]     o_io_hex5,
  output logic [lsu_pkg::HEX_SEG_W-1:0]     o_io_hex6,
  output logic [lsu_pkg::HEX_SEG_W-1:0]     o_io_hex7
);
  import lsu_pkg::*;

  logic [DATA_W-1:0]               mem_rdata;
  logic [DATA_W-1:0]               io_rdata;
  logic [HEX_DIGITS*HEX_SEG_W-1:0] hex_bus;

  lsu_bus_if #(.MEM_WORDS(MEM_WORDS)) lsu_bus ();

  lsu_access_decode #(.MEM_WORDS(MEM_WORDS)) u_decode (
    .i_lsu_addr (i_lsu_addr),
    .i_lsu_wren (i_lsu_wren),
    .i_funct3   (lsu_op_e'(i_funct3)),  // Raw funct3, invalid codes kept
    .i_st_data  (i_st_data),
    .bus        (lsu_bus)
  );

  lsu_data_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .i_clk   (i_clk),
    .bus     (lsu_bus),
    .o_rdata (mem_rdata)
  );

  lsu_io_regs u_io (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .bus       (lsu_bus),
    .i_io_sw   (i_io_sw),
    .o_io_ledr (o_io_ledr),
    .o_io_ledg (o_io_ledg),
    .o_io_hex  (hex_bus),
    .o_rdata   (io_rdata)
  );

  lsu_load_format u_load (
    .bus         (lsu_bus),
    .i_mem_rdata (mem_rdata),
    .i_io_rdata  (io_rdata),
    .o_ld_data   (o_ld_data)
  );

  assign o_io_hex0 = hex_bus[0*HEX_SEG_W +: HEX_SEG_W];
  assign o_io_hex1 = hex_bus[1*HEX_SEG_W +: HEX_SEG_W];
  assign o_io_hex2 = hex_bus[2*HEX_SEG_W +: HEX_SEG_W];
  assign o_io_hex3 = hex_bus[3*HEX_SEG_W +: HEX_SEG_W];
  assign o_io_hex4 = hex_bus[4*HEX_SEG_W +: HEX_SEG_W];
  assign o_io_hex5 = hex_bus[5*HEX_SEG_W +: HEX_SEG_W];
  assign o_io_hex6 = hex_bus[6*HEX_SEG_W +: HEX_SEG_W];
  assign o_io_hex7 = hex_bus[7*HEX_SEG_W +: HEX_SEG_W];

endmodule

//--- tests/lsu_assertions.sv
`timescale 1ns/1ps

module lsu_assertions (
  input logic        i_clk,
  input logic        i_rst,
  input logic [31:0] i_lsu_addr,
  input logic        i_lsu_wren,
  input logic [31:0] i_ld_data,
  input logic [16:0] i_io_ledr,
  input logic [7:0]  i_io_ledg,
  input logic [55:0] i_io_hex
);
  import lsu_pkg::*;

  int unsigned fail_count = 0;
  logic        mapped;

  assign mapped = (i_lsu_addr >= MEM_START && i_lsu_addr <= MEM_END) ||
                  (i_lsu_addr >= LEDR_START && i_lsu_addr <= LEDG_END) ||
                  (i_lsu_addr >= HEX_LO_ADDR && i_lsu_addr <= HEX_HI_ADDR + 3) ||
                  (i_lsu_addr >= SW_START && i_lsu_addr <= SW_END);

  store_cycle_load_zero: assert property (@(posedge i_clk) disable iff (!i_rst)
    i_lsu_wren |-> i_ld_data == '0)
    else begin
      fail_count++;
      $error("load data is not zero during a store cycle");
    end

  outputs_clear_after_reset: assert property (@(posedge i_clk)
    $rose(i_rst) |-> (i_io_ledr == '0 && i_io_ledg == '0 && i_io_hex == '0))
    else begin
      fail_count++;
      $error("LED or digit outputs are not clear after reset");
    end

  unmapped_load_zero: assert property (@(posedge i_clk) disable iff (!i_rst)
    !mapped |-> i_ld_data == '0)
    else begin
      fail_count++;
      $error("load from an unmapped address is not zero");
    end

endmodule

bind lsu_top lsu_assertions u_assertions (
  .i_clk      (i_clk),
  .i_rst      (i_rst),
  .i_lsu_addr (i_lsu_addr),
  .i_lsu_wren (i_lsu_wren),
  .i_ld_data  (o_ld_data),
  .i_io_ledr  (o_io_ledr),
  .i_io_ledg  (o_io_ledg),
  .i_io_hex   ({o_io_hex7, o_io_hex6, o_io_hex5, o_io_hex4,
                o_io_hex3, o_io_hex2, o_io_hex1, o_io_hex0})
);

//--- tests/lsu_checker.sv
`timescale 1ns/1ps

module lsu_checker (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic [31:0] i_lsu_addr,
  input  logic        i_lsu_wren,
  input  logic [2:0]  i_funct3,
  input  logic [31:0] i_st_data,
  input  logic [9:0]  i_io_sw,
  input  logic [31:0] i_ld_data,
  input  logic [16:0] i_io_ledr,
  input  logic [7:0]  i_io_ledg,
  input  logic [55:0] i_io_hex,
  output int unsigned o_error_count
);

  logic [7:0]  mem_b [64];  // Bytes 0x2000 to 0x203F
  logic [7:0]  digit [8];
  logic [16:0] ledr;
  logic [7:0]  ledg;
  logic [9:0]  sw;
  int unsigned check_count = 0;
  int unsigned error_count = 0;

  assign o_error_count = error_count;

  // 0 none, 1 memory, 2 red LED, 3 green LED, 4 digits 0-3, 5 digits 4-7, 6 switches
  function automatic int region_of(input logic [31:0] a);
    if (a >= 32'h2000 && a <= 32'h3FFF) return 1;
    if (a >= 32'h7000 && a <= 32'h700F) return 2;
    if (a >= 32'h7010 && a <= 32'h701F) return 3;
    if (a >= 32'h7020 && a <= 32'h7023) return 4;
    if (a >= 32'h7024 && a <= 32'h7027) return 5;
    if (a >= 32'h7800 && a <= 32'h780F) return 6;
    return 0;
  endfunction

  function automatic logic [31:0] expect_load(input logic [31:0] a, input logic [2:0] f3,
                                              input logic we);
    logic [7:0] b [4];
    int rg;
    int k;
    rg = region_of(a);
    k = a[1:0];
    if (we || rg == 0) return '0;
    if (rg == 2) return {15'd0, ledr};
    if (rg == 3) return {24'd0, ledg};
    if (rg == 6) return {22'd0, sw};
    for (int i = 0; i < 4; i++) begin
      b[i] = (rg == 1) ? mem_b[{a[5:2], 2'b00} + i] : digit[(rg == 5 ? 4 : 0) + i];
    end
    case (f3)
      3'b000: return {{24{b[k][7]}}, b[k]};
      3'b100: return {24'd0, b[k]};
      3'b001: if (k < 3) return {{16{b[k+1][7]}}, b[k+1], b[k]};
      3'b101: if (k < 3) return {16'd0, b[k+1], b[k]};
      3'b010: if (k == 0) return {b[3], b[2], b[1], b[0]};
      default: return '0;
    endcase
    return '0;  // Misaligned half or word
  endfunction

  task automatic apply_store(input logic [31:0] a, input logic [2:0] f3, input logic [31:0] d);
    int rg;
    int k;
    int n;
    rg = region_of(a);
    k = a[1:0];
    n = 0;
    if (f3 == 3'b000) n = 1;
    else if (f3 == 3'b001 && k <= 2) n = 2;
    else if (f3 == 3'b010 && k == 0) n = 4;
    for (int j = 0; j < n; j++) begin
      if (rg == 1) mem_b[a[5:0] + j] = d[8*j +: 8];
      if (rg == 4 || rg == 5) digit[(rg == 5 ? 4 : 0) + k + j] = d[8*j +: 8];
    end
    if (rg == 2) ledr = d[16:0];  // Any op writes the LEDs
    if (rg == 3) ledg = d[7:0];
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t: %s is %h, expected %h (addr %h funct3 %0d wren %b)",
               $time, what, got, exp, i_lsu_addr, i_funct3, i_lsu_wren);
    end
  endtask

  task print_summary(input int unsigned assert_fails);
    $display("Checker: %0d checks, %0d mismatches, %0d assertion failures",
             check_count, error_count, assert_fails);
  endtask

  always @(posedge i_clk) begin
    if (!i_rst) begin
      ledr = '0;
      ledg = '0;
      sw = '0;
      for (int i = 0; i < 8; i++) digit[i] = '0;
    end else begin
      check_value("load data", i_ld_data, expect_load(i_lsu_addr, i_funct3, i_lsu_wren));
      check_value("red LEDs", i_io_ledr, ledr);
      check_value("green LEDs", i_io_ledg, ledg);
      for (int g = 0; g < 8; g++) begin
        check_value($sformatf("hex%0d", g), i_io_hex[7*g +: 7], digit[g][6:0]);
      end
      if (i_lsu_wren) apply_store(i_lsu_addr, i_funct3, i_st_data);
      sw = i_io_sw;  // Switches seen one cycle later
    end
  end

endmodule

//--- tests/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

  localparam int CYCLE_LIMIT = 2 + 16 + 600 + 50;

  logic        clk;
  logic        rst;
  logic [31:0] addr;
  logic        wren;
  logic [2:0]  funct3;
  logic [31:0] st_data;
  logic [9:0]  sw;
  logic [31:0] ld_data;
  logic [16:0] ledr;
  logic [7:0]  ledg;
  logic [6:0]  hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;
  int unsigned error_count;
  integer      seed = 20;
  int          cycle_count = 0;

  lsu_top #(.MEM_WORDS(256)) u_lsu_top (
    .i_clk(clk), .i_rst(rst), .i_lsu_addr(addr), .i_lsu_wren(wren), .i_funct3(funct3),
    .i_st_data(st_data), .i_io_sw(sw), .o_ld_data(ld_data), .o_io_ledr(ledr),
    .o_io_ledg(ledg), .o_io_hex0(hex0), .o_io_hex1(hex1), .o_io_hex2(hex2),
    .o_io_hex3(hex3), .o_io_hex4(hex4), .o_io_hex5(hex5), .o_io_hex6(hex6),
    .o_io_hex7(hex7)
  );

  lsu_checker u_checker (
    .i_clk(clk), .i_rst(rst), .i_lsu_addr(addr), .i_lsu_wren(wren), .i_funct3(funct3),
    .i_st_data(st_data), .i_io_sw(sw), .i_ld_data(ld_data), .i_io_ledr(ledr),
    .i_io_ledg(ledg), .i_io_hex({hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0}),
    .o_error_count(error_count)
  );

  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Applies one access and holds it for a full cycle
  task automatic drive_access(input logic [31:0] a, input logic [2:0] f3, input logic we,
                              input logic [31:0] d);
    logic [31:0] r;
    r = $random(seed);
    addr = a;
    funct3 = f3;
    wren = we;
    st_data = d;
    sw = r[9:0];
    @(posedge clk);
    #1;
  endtask

  task automatic pick_address(output logic [31:0] a);
    logic [31:0] r;
    r = $random(seed);
    case (r[2:0])
      3'd0, 3'd1, 3'd2, 3'd3: a = 32'h2000 + {r[5:3], 10'h000} + r[11:6];  // Aliases of window
      3'd4: a = 32'h7020 + r[5:3];  // Both digit windows
      3'd5: a = 32'h7000 + r[7:3];  // Red and green LEDs
      3'd6: a = 32'h7800 + r[6:3];
      default: a = r[3] ? (32'h7028 + r[7:4]) : (32'h4000 + r[15:4]);  // Unmapped
    endcase
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] r;
    int unsigned assert_fails;
    clk = 1'b0;
    rst = 1'b0;
    addr = '0;
    wren = 1'b0;
    funct3 = '0;
    st_data = '0;
    sw = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b1;
    for (int i = 0; i < 16; i++) begin
      drive_access(32'h2000 + 4 * i, 3'b010, 1'b1, $random(seed));  // Fill the window
    end
    for (int n = 0; n < 600; n++) begin
      pick_address(a);
      r = $random(seed);
      drive_access(a, r[2:0], r[4], $random(seed));
    end
    drive_access(32'h0, 3'b010, 1'b0, 32'h0);
    drive_access(32'h0, 3'b010, 1'b0, 32'h0);
    assert_fails = u_lsu_top.u_assertions.fail_count;
    u_checker.print_summary(assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- verilog.f
src/lsu_pkg.sv
src/lsu_bus_if.sv
src/lsu_access_decode.sv
src/lsu_data_mem.sv
src/lsu_io_regs.sv
src/lsu_load_format.sv
src/lsu_top.sv
tests/lsu_assertions.sv
tests/lsu_checker.sv
tests/lsu_tb.sv
